/* tests/uart_stimulus.txt */
# op W addr data | R addr expect mask | F nbits frame_bits | Q quiet_clocks
# op C cts_level | T rts_expect ; fields in hex, raw frame bits go out lsb first
R 0 00000000 ffffffff
R 1 00000001 ffffffff
R 2 00000001 ffffffff
R 3 00000010 ffffffff
W 0 55
W 0 a3
W 0 00
W 0 ff
Q d0
R 0 00000055 ffffffff
R 0 000000a3 ffffffff
R 0 00000000 ffffffff
R 0 000000ff ffffffff
R 0 00000000 ffffffff
R 1 00000001 ffffffff
W 2 6
R 2 00000006 ffffffff
W 0 c5
W 0 7e
W 0 b1
Q d0
R 0 00000045 ffffffff
R 0 0000007e ffffffff
R 0 00000031 ffffffff
R 0 00000000 ffffffff
W 2 5
F b 61e
Q d0
R 0 0000040f ffffffff
F b 078
Q d0
R 0 0000023c ffffffff
R 1 00000001 0000000f
W 2 1
W 0 11
W 0 12
W 0 13
W 0 14
W 0 15
W 0 16
W 0 17
W 0 18
W 0 19
Q d0
R 1 0000000a 0000001f
R 0 00000011 ffffffff
R 0 00000012 ffffffff
R 0 00000013 ffffffff
R 0 00000014 ffffffff
R 0 00000015 ffffffff
R 0 00000016 ffffffff
R 0 00000017 ffffffff
R 0 00000018 ffffffff
R 0 00000000 ffffffff
R 1 00000001 0000001f
W 2 9
W 0 21
W 0 22
W 0 23
W 0 24
Q d0
T 0
W 0 25
Q d0
T 1
R 0 00000021 ffffffff
R 0 00000022 ffffffff
R 0 00000023 ffffffff
R 0 00000024 ffffffff
R 0 00000025 ffffffff
T 0
C 1
Q d0
W 0 5a
Q d0
R 0 00000000 ffffffff
C 0
Q d0
R 0 0000005a ffffffff
R 1 00000001 ffffffff

/* sources.f */
+incdir+rtl
rtl/uart_pkg.sv
rtl/fifo_buf.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/uart_regs.sv
rtl/uart_top.sv
tests/uart_checker.sv
tests/uart_tb.sv

/* run.sh */
#!/bin/sh
# build the uart testbench with verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module uart_tb -f sources.f -o uart_sim \
	&& ./obj_dir/uart_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q '^\*\* PASS \*\*$' sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* tests/uart_tb.sv */
`timescale 1ns/1ps

module uart_tb;

	localparam int    CLK_NS      = 20;
	localparam int    RAW_DIV     = 16;
	// longest frame is start, 8 data, parity and 2 stop bits
	localparam int    FRAME_NS    = 12 * RAW_DIV * CLK_NS;
	localparam int    QUIET_LIMIT = 8000;
	localparam string STIM_FILE   = "tests/uart_stimulus.txt";

	logic        clk;
	logic        reset;
	logic        wr;
	logic        rd;
	logic [1:0]  addr;
	logic [31:0] wdata;
	logic [31:0] rdata;
	logic        rdata_valid;
	logic        tx;
	logic        rx;
	logic        rts;
	logic        cts;
	logic        raw_active;
	logic        raw_bit;
	logic [31:0] exp_data;
	logic [31:0] exp_mask;
	logic        rts_check;
	logic        rts_exp;
	int          check_count;
	int          error_count;
	int          tb_errors;
	int          fd;
	int          op_count;
	longint      watch_limit;
	logic [7:0]  op;

	// serial loopback unless a raw frame owns the line
	assign rx = raw_active ? raw_bit : tx;

	uart_top u_uart_top (
		.clk         (clk),
		.reset       (reset),
		.wr          (wr),
		.rd          (rd),
		.addr        (addr),
		.wdata       (wdata),
		.rdata       (rdata),
		.rdata_valid (rdata_valid),
		.tx          (tx),
		.rx          (rx),
		.rts         (rts),
		.cts         (cts)
	);

	uart_checker u_checker (
		.clk         (clk),
		.reset       (reset),
		.rd          (rd),
		.addr        (addr),
		.exp_data    (exp_data),
		.exp_mask    (exp_mask),
		.rdata       (rdata),
		.rdata_valid (rdata_valid),
		.rts_check   (rts_check),
		.rts_exp     (rts_exp),
		.rts         (rts),
		.tx          (tx),
		.check_count (check_count),
		.error_count (error_count)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	task automatic skip_line();
		int ch;
		ch = $fgetc(fd);
		while (ch != 10 && ch != -1)
			ch = $fgetc(fd);
	endtask

	task automatic count_ops(output int n);
		logic [7:0] c;
		n = 0;
		while ($fscanf(fd, " %c", c) == 1) begin
			if (c != "#")
				n++;
			skip_line();
		end
	endtask

	task automatic write_reg(input logic [1:0] a, input logic [31:0] d);
		@(posedge clk);
		#1;
		wr    = 1'b1;
		addr  = a;
		wdata = d;
		@(posedge clk);
		#1;
		wr = 1'b0;
	endtask

	// expected value rides along with the strobe into the checker
	task automatic read_reg(input logic [1:0] a, input logic [31:0] d, input logic [31:0] m);
		@(posedge clk);
		#1;
		rd       = 1'b1;
		addr     = a;
		exp_data = d;
		exp_mask = m;
		@(posedge clk);
		#1;
		rd = 1'b0;
	endtask

	task automatic send_frame(input int nbits, input logic [31:0] bits);
		@(posedge clk);
		#1;
		raw_active = 1'b1;
		for (int i = 0; i < nbits; i++) begin
			raw_bit = bits[i];
			repeat (RAW_DIV) @(posedge clk);
			#1;
		end
		raw_active = 1'b0;
		raw_bit    = 1'b1;
	endtask

	// line is quiet once tx and rx have both idled high long enough
	task automatic wait_quiet(input int cycles);
		int run;
		int spent;
		run   = 0;
		spent = 0;
		while (run < cycles && spent < QUIET_LIMIT) begin
			@(negedge clk);
			spent++;
			if (tx && rx)
				run++;
			else
				run = 0;
		end
		if (run < cycles) begin
			$display("serial line still busy after %0d cycles at %0t", QUIET_LIMIT, $time);
			tb_errors++;
		end
	endtask

	task automatic expect_rts(input logic level);
		@(posedge clk);
		#1;
		rts_check = 1'b1;
		rts_exp   = level;
		@(posedge clk);
		#1;
		rts_check = 1'b0;
	endtask

	task automatic run_op(input logic [7:0] code);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		int          n;
		int          want;
		n    = 0;
		want = 0;
		case (code)
			"W": begin
				want = 2;
				n    = $fscanf(fd, "%h %h", a, b);
				write_reg(a[1:0], b);
			end
			"R": begin
				want = 3;
				n    = $fscanf(fd, "%h %h %h", a, b, c);
				read_reg(a[1:0], b, c);
			end
			"F": begin
				want = 2;
				n    = $fscanf(fd, "%h %h", a, b);
				send_frame(a, b);
			end
			"Q": begin
				want = 1;
				n    = $fscanf(fd, "%h", a);
				wait_quiet(a);
			end
			"C": begin
				want = 1;
				n    = $fscanf(fd, "%h", a);
				@(posedge clk);
				#1;
				cts = a[0];
			end
			"T": begin
				want = 1;
				n    = $fscanf(fd, "%h", a);
				expect_rts(a[0]);
			end
			default: begin
				$display("unknown stimulus operation '%c' at %0t", code, $time);
				tb_errors++;
				skip_line();
			end
		endcase
		if (n != want) begin
			$display("stimulus line for operation '%c' has missing fields at %0t", code, $time);
			tb_errors++;
		end
	endtask

	initial begin
		reset       = 1'b1;
		wr          = 1'b0;
		rd          = 1'b0;
		addr        = 2'd0;
		wdata       = 32'd0;
		cts         = 1'b0;
		raw_active  = 1'b0;
		raw_bit     = 1'b1;
		exp_data    = 32'd0;
		exp_mask    = 32'd0;
		rts_check   = 1'b0;
		rts_exp     = 1'b0;
		tb_errors   = 0;
		op_count    = 0;
		watch_limit = 0;
		fd = $fopen(STIM_FILE, "r");
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		if (fd == 0) begin
			$display("cannot open the stimulus file %s", STIM_FILE);
			$display("** FAIL **");
			$finish;
		end else begin
			count_ops(op_count);
			$fclose(fd);
			fd = $fopen(STIM_FILE, "r");
			watch_limit = longint'(op_count) * 12 * FRAME_NS;
			while ($fscanf(fd, " %c", op) == 1) begin
				if (op == "#")
					skip_line();
				else
					run_op(op);
			end
			$fclose(fd);
			repeat (4) @(posedge clk);
			$display("operations: %0d, checks: %0d, checker errors: %0d, testbench errors: %0d",
			         op_count, check_count, error_count, tb_errors);
			if (error_count == 0 && tb_errors == 0)
				$display("** PASS **");
			else
				$display("** FAIL **");
			$finish;
		end
	end

	// watchdog, armed once the operations are counted
	initial begin
		wait (watch_limit != 0);
		#(watch_limit);
		$display("watchdog expired at %0t before the stimulus finished", $time);
		$display("** FAIL **");
		$finish;
	end

endmodule

/* tests/uart_checker.sv */
`timescale 1ns/1ps

module uart_checker (
	input  logic        clk,
	input  logic        reset,
	input  logic        rd,
	input  logic [1:0]  addr,
	input  logic [31:0] exp_data,
	input  logic [31:0] exp_mask,
	input  logic [31:0] rdata,
	input  logic        rdata_valid,
	input  logic        rts_check,
	input  logic        rts_exp,
	input  logic        rts,
	input  logic        tx,
	output int          check_count,
	output int          error_count
);

	logic        pend;
	logic [1:0]  pend_addr;
	logic [31:0] pend_data;
	logic [31:0] pend_mask;
	logic        fresh;

	always @(posedge clk or posedge reset) begin
		if (reset) begin
			pend        <= 1'b0;
			fresh       <= 1'b1;
			check_count = 0;
			error_count = 0;
		end else begin
			// first edge out of reset, outputs must be idle
			if (fresh) begin
				check_count = check_count + 1;
				if (tx !== 1'b1 || rts !== 1'b0 || rdata_valid !== 1'b0) begin
					$display("FAIL %0t: outputs not idle after reset, tx %b rts %b rdata_valid %b",
					         $time, tx, rts, rdata_valid);
					error_count = error_count + 1;
				end
			end
			fresh <= 1'b0;
			if ($isunknown(tx)) begin
				$display("FAIL %0t: tx line is unknown", $time);
				error_count = error_count + 1;
			end
			// a read strobe owes exactly one rdata_valid on the next edge
			if (pend) begin
				check_count = check_count + 1;
				if (rdata_valid !== 1'b1) begin
					$display("FAIL %0t: rdata_valid did not follow the read of register %0d",
					         $time, pend_addr);
					error_count = error_count + 1;
				end else if ((rdata & pend_mask) !== (pend_data & pend_mask)) begin
					$display("FAIL %0t: register %0d read %h, expected %h under mask %h",
					         $time, pend_addr, rdata, pend_data, pend_mask);
					error_count = error_count + 1;
				end
			end else if (rdata_valid === 1'b1) begin
				$display("FAIL %0t: rdata_valid came without a read", $time);
				error_count = error_count + 1;
			end
			if (rts_check) begin
				check_count = check_count + 1;
				if (rts !== rts_exp) begin
					$display("FAIL %0t: rts is %b, expected %b", $time, rts, rts_exp);
					error_count = error_count + 1;
				end
			end
			pend      <= rd;
			pend_addr <= addr;
			pend_data <= exp_data;
			pend_mask <= exp_mask;
		end
	end

endmodule

/* rtl/uart_top.sv */
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_top (
	input  logic        clk,
	input  logic        reset,
	input  logic        wr,
	input  logic        rd,
	input  logic [1:0]  addr,
	input  logic [31:0] wdata,
	output logic [31:0] rdata,
	output logic        rdata_valid,
	output logic        tx,
	input  logic        rx,
	output logic        rts,
	input  logic        cts
);

	import uart_pkg::*;

	frame_cfg_t  frame_cfg;
	logic [23:0] baud_reg;
	logic        clear;
	logic        tx_push;
	logic [7:0]  tx_wbyte;
	logic [7:0]  tx_head;
	logic        tx_pop;
	logic        tx_empty;
	logic        tx_full;
	rx_entry_t   rx_entry;
	logic        rx_pop;
	logic        rx_empty;
	logic        rx_full;
	logic        noise_error;
	logic        overflow_error;

	uart_regs u_regs (
		.clk            (clk),
		.reset          (reset),
		.wr             (wr),
		.rd             (rd),
		.addr           (addr),
		.wdata          (wdata),
		.rdata          (rdata),
		.rdata_valid    (rdata_valid),
		.rx_entry       (rx_entry),
		.rx_empty       (rx_empty),
		.rx_full        (rx_full),
		.tx_full        (tx_full),
		.noise_error    (noise_error),
		.overflow_error (overflow_error),
		.tx_push        (tx_push),
		.tx_byte        (tx_wbyte),
		.rx_pop         (rx_pop),
		.clear          (clear),
		.frame_cfg      (frame_cfg),
		.baud_reg       (baud_reg)
	);

	// transmit queue, plain bytes
	fifo_buf #(
		.ADDR_WIDTH (`UART_FIFO_AW),
		.payload_t  (logic [7:0])
	) u_tx_fifo (
		.clk   (clk),
		.reset (reset),
		.clear (clear),
		.wena  (tx_push),
		.wdata (tx_wbyte),
		.rena  (tx_pop),
		.rdata (tx_head),
		.size  (),
		.empty (tx_empty),
		.full  (tx_full)
	);

	uart_tx u_tx (
		.clk       (clk),
		.reset     (reset),
		.tx_empty  (tx_empty),
		.tx_byte   (tx_head),
		.cts       (cts),
		.frame_cfg (frame_cfg),
		.baud_reg  (baud_reg),
		.tx_pop    (tx_pop),
		.tx        (tx)
	);

	uart_rx #(
		.ADDR_WIDTH (`UART_FIFO_AW)
	) u_rx (
		.clk            (clk),
		.reset          (reset),
		.clear          (clear),
		.rx             (rx),
		.frame_cfg      (frame_cfg),
		.baud_reg       (baud_reg),
		.rena           (rx_pop),
		.rdata          (rx_entry),
		.size           (),
		.empty          (rx_empty),
		.full           (rx_full),
		.rts            (rts),
		.noise_error    (noise_error),
		.overflow_error (overflow_error)
	);

endmodule

/* rtl/uart_regs.sv */
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_regs (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 wr,
	input  logic                 rd,
	input  logic [1:0]           addr,
	input  logic [31:0]          wdata,
	output logic [31:0]          rdata,
	output logic                 rdata_valid,
	input  uart_pkg::rx_entry_t  rx_entry,
	input  logic                 rx_empty,
	input  logic                 rx_full,
	input  logic                 tx_full,
	input  logic                 noise_error,
	input  logic                 overflow_error,
	output logic                 tx_push,
	output logic [7:0]           tx_byte,
	output logic                 rx_pop,
	output logic                 clear,
	output uart_pkg::frame_cfg_t frame_cfg,
	output logic [23:0]          baud_reg
);

	import uart_pkg::*;

	logic status_rd;
	logic overflow_sticky;
	logic noise_sticky;

	assign tx_push   = wr && addr == `UART_ADDR_DATA && !tx_full;
	assign tx_byte   = wdata[7:0];
	assign rx_pop    = rd && addr == `UART_ADDR_DATA && !rx_empty;
	// new frame format flushes both queues
	assign clear     = wr && addr == `UART_ADDR_CONFIG;
	assign status_rd = rd && addr == `UART_ADDR_STATUS;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			// 8N1, no flow control
			frame_cfg       <= frame_cfg_t'(4'b0001);
			baud_reg        <= `UART_BAUD_RESET;
			overflow_sticky <= 1'b0;
			noise_sticky    <= 1'b0;
			rdata_valid     <= 1'b0;
		end else begin
			if (clear)
				frame_cfg <= frame_cfg_t'(wdata[3:0]);
			if (wr && addr == `UART_ADDR_BAUD)
				baud_reg <= wdata[23:0];
			// a new error in the same cycle as the read is kept
			overflow_sticky <= overflow_error || (overflow_sticky && !status_rd);
			noise_sticky    <= noise_error || (noise_sticky && !status_rd);
			rdata_valid     <= rd;
		end
	end

	always_ff @(posedge clk) begin
		if (rd) begin
			case (addr)
				`UART_ADDR_DATA:   rdata <= rx_empty ? 32'd0 : {21'd0, rx_entry};
				`UART_ADDR_STATUS: rdata <= {27'd0, noise_sticky, overflow_sticky,
				                             tx_full, rx_full, rx_empty};
				`UART_ADDR_CONFIG: rdata <= {28'd0, frame_cfg};
				default:           rdata <= {8'd0, baud_reg};
			endcase
		end
	end

endmodule

/* rtl/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 tx_empty,
	input  logic [7:0]           tx_byte,
	input  logic                 cts,
	input  uart_pkg::frame_cfg_t frame_cfg,
	input  logic [23:0]          baud_reg,
	output logic                 tx_pop,
	output logic                 tx
);

	typedef enum logic [2:0] {IDLE, START, DATA, PARITY, STOP} tx_state_t;

	tx_state_t   state;
	logic [1:0]  cts_sync;
	logic [23:0] counter;
	logic        bit_end;
	logic [2:0]  bit_idx;
	logic [7:0]  shift;
	logic        parity_bit;
	logic [7:0]  frame_byte;

	// a frame starts only from idle, so each frame pops once
	assign tx_pop     = state == IDLE && !tx_empty && !(frame_cfg.flow_ctrl && cts_sync[1]);
	assign bit_end    = counter == baud_reg - 24'd1;
	assign frame_byte = frame_cfg.data_bits ? tx_byte : {1'b0, tx_byte[6:0]};

	always_ff @(posedge clk, posedge reset) begin
		if (reset)
			cts_sync <= 2'b00;
		else
			cts_sync <= {cts_sync[0], cts};
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			state      <= IDLE;
			tx         <= 1'b1;
			counter    <= '0;
			bit_idx    <= '0;
			shift      <= '0;
			parity_bit <= 1'b0;
		end else begin
			counter <= bit_end ? '0 : counter + 24'd1;
			case (state)
				IDLE: begin
					counter <= '0;
					if (tx_pop) begin
						shift      <= frame_byte;
						parity_bit <= ^frame_byte;
						tx         <= 1'b0;
						state      <= START;
					end
				end
				START: begin
					if (bit_end) begin
						tx      <= shift[0];
						bit_idx <= '0;
						state   <= DATA;
					end
				end
				DATA: begin
					if (bit_end) begin
						if (bit_idx == 3'd6 + {2'b00, frame_cfg.data_bits}) begin
							tx      <= frame_cfg.parity ? parity_bit : 1'b1;
							bit_idx <= '0;
							state   <= frame_cfg.parity ? PARITY : STOP;
						end else begin
							shift   <= shift >> 1;
							tx      <= shift[1];
							bit_idx <= bit_idx + 3'd1;
						end
					end
				end
				PARITY: begin
					if (bit_end) begin
						tx    <= 1'b1;
						state <= STOP;
					end
				end
				STOP: begin
					if (bit_end) begin
						if (bit_idx == {2'b00, frame_cfg.stop_bits})
							state <= IDLE;
						else
							bit_idx <= bit_idx + 3'd1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// the line rests high whenever no frame is in flight
	a_idle_line_high: assert property (@(posedge clk) disable iff (reset)
		state == IDLE |-> tx);

endmodule

/* rtl/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx #(
	parameter int ADDR_WIDTH = 3
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 clear,
	input  logic                 rx,
	input  uart_pkg::frame_cfg_t frame_cfg,
	input  logic [23:0]          baud_reg,
	input  logic                 rena,
	output uart_pkg::rx_entry_t  rdata,
	output logic [ADDR_WIDTH:0]  size,
	output logic                 empty,
	output logic                 full,
	output logic                 rts,
	output logic                 noise_error,
	output logic                 overflow_error
);

	import uart_pkg::*;

	typedef enum logic [2:0] {IDLE, START, DATA, PARITY, STOP} rx_state_t;

	rx_state_t   state;
	logic [1:0]  rx_sync;
	logic [24:0] counter;
	logic [24:0] bit_len;
	logic [24:0] pos_lo;
	logic [24:0] pos_mid;
	logic [24:0] pos_hi;
	logic [24:0] stop_end;
	logic        last_cnt;
	logic        long_stop;
	logic [2:0]  samples;
	logic        sample;
	logic        sample_noisy;
	logic [2:0]  bit_idx;
	logic [7:0]  shift;
	logic        noise_acc;
	logic        parity_err;
	logic        abort;
	logic        capture;
	logic        wena;
	rx_entry_t   entry;

	assign bit_len   = {1'b0, baud_reg};
	assign last_cnt  = counter == bit_len - 25'd1;
	// with two stop bits the sample window is stretched over both
	assign long_stop = state == STOP && frame_cfg.stop_bits;
	assign pos_mid   = long_stop ? bit_len : bit_len >> 1;
	assign pos_lo    = long_stop ? bit_len - (bit_len >> 3) : (bit_len >> 1) - (bit_len >> 4);
	assign pos_hi    = long_stop ? bit_len + (bit_len >> 3) : (bit_len >> 1) + (bit_len >> 4);
	assign stop_end  = frame_cfg.stop_bits ? (bit_len << 1) - 25'd2 : bit_len - 25'd2;

	// majority of three
	assign sample       = (samples[0] & samples[1]) | (samples[1] & samples[2]) |
	                      (samples[0] & samples[2]);
	assign sample_noisy = !(samples == 3'b111 || samples == 3'b000);

	assign capture        = state == STOP && !wena && counter == stop_end;
	assign noise_error    = (wena && entry.noise) || abort;
	assign overflow_error = wena && full;
	// raised early so the far end can stop before the fifo fills
	assign rts            = frame_cfg.flow_ctrl && (size > 2**ADDR_WIDTH - 4);

	always_ff @(posedge clk, posedge reset) begin
		if (reset)
			rx_sync <= 2'b11;
		else
			rx_sync <= {rx_sync[0], rx};
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			state      <= IDLE;
			counter    <= '0;
			samples    <= '0;
			bit_idx    <= '0;
			shift      <= '0;
			noise_acc  <= 1'b0;
			parity_err <= 1'b0;
			abort      <= 1'b0;
			wena       <= 1'b0;
		end else begin
			if (state != IDLE) begin
				if (counter == pos_lo)
					samples[0] <= rx_sync[1];
				if (counter == pos_mid)
					samples[1] <= rx_sync[1];
				if (counter == pos_hi)
					samples[2] <= rx_sync[1];
			end
			case (state)
				IDLE: begin
					noise_acc  <= 1'b0;
					parity_err <= 1'b0;
					abort      <= 1'b0;
					bit_idx    <= '0;
					shift      <= '0;
					// falling edge already took one cycle to see
					counter    <= 25'd1;
					if (!rx_sync[1])
						state <= START;
				end
				START: begin
					if (last_cnt) begin
						counter <= '0;
						if (!sample) begin
							noise_acc <= sample_noisy;
							state     <= DATA;
						end else begin
							// glitch, not a start bit
							abort <= 1'b1;
							state <= IDLE;
						end
					end else
						counter <= counter + 25'd1;
				end
				DATA: begin
					if (last_cnt) begin
						// lsb arrives first
						shift     <= {sample, shift[7:1]};
						noise_acc <= noise_acc || sample_noisy;
						counter   <= '0;
						if (bit_idx == 3'd6 + {2'b00, frame_cfg.data_bits})
							state <= frame_cfg.parity ? PARITY : STOP;
						else
							bit_idx <= bit_idx + 3'd1;
					end else
						counter <= counter + 25'd1;
				end
				PARITY: begin
					if (last_cnt) begin
						noise_acc  <= noise_acc || sample_noisy;
						parity_err <= sample != ^shift;
						counter    <= '0;
						state      <= STOP;
					end else
						counter <= counter + 25'd1;
				end
				STOP: begin
					if (wena) begin
						wena    <= 1'b0;
						counter <= '0;
						state   <= IDLE;
					end else begin
						if (capture)
							wena <= 1'b1;
						counter <= counter + 25'd1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			// seven bit data sits one place too high
			entry.data   <= shift >> !frame_cfg.data_bits;
			entry.noise  <= noise_acc || sample_noisy;
			entry.parity <= parity_err;
			entry.frame  <= !sample;
		end
	end

	a_state_legal: assert property (@(posedge clk) disable iff (reset)
		state inside {IDLE, START, DATA, PARITY, STOP});

	fifo_buf #(
		.ADDR_WIDTH (ADDR_WIDTH),
		.payload_t  (rx_entry_t)
	) u_rx_fifo (
		.clk   (clk),
		.reset (reset),
		.clear (clear),
		.wena  (wena),
		.wdata (entry),
		.rena  (rena),
		.rdata (rdata),
		.size  (size),
		.empty (empty),
		.full  (full)
	);

endmodule

/* rtl/fifo_buf.sv */
`timescale 1ns/1ps

module fifo_buf #(
	parameter int  ADDR_WIDTH = 3,
	parameter type payload_t  = logic [7:0]
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  clear,
	input  logic                  wena,
	input  payload_t              wdata,
	input  logic                  rena,
	output payload_t              rdata,
	output logic [ADDR_WIDTH:0]   size,
	output logic                  empty,
	output logic                  full
);

	payload_t              mem [2**ADDR_WIDTH];
	logic [ADDR_WIDTH-1:0] wptr;
	logic [ADDR_WIDTH-1:0] rptr;
	logic                  do_write;
	logic                  do_read;

	assign empty    = size == '0;
	assign full     = size[ADDR_WIDTH];
	assign do_write = wena && !full;
	assign do_read  = rena && !empty;
	// head entry is always visible
	assign rdata    = mem[rptr];

	always_ff @(posedge clk) begin
		if (do_write)
			mem[wptr] <= wdata;
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			wptr <= '0;
			rptr <= '0;
			size <= '0;
		end else if (clear) begin
			wptr <= '0;
			rptr <= '0;
			size <= '0;
		end else begin
			if (do_write)
				wptr <= wptr + 1'b1;
			if (do_read)
				rptr <= rptr + 1'b1;
			size <= size + {{ADDR_WIDTH{1'b0}}, do_write} - {{ADDR_WIDTH{1'b0}}, do_read};
		end
	end

	// a write into a full buffer must never grow it
	a_no_write_when_full: assert property (@(posedge clk) disable iff (reset)
		(wena && full && !clear) |=> (size <= $past(size)));

endmodule

/* rtl/uart_pkg.sv */
package uart_pkg;

	// runtime frame format as written to the config register
	// bit 3 flow_ctrl, bit 2 parity, bit 1 stop_bits, bit 0 data_bits
	typedef struct packed {
		logic flow_ctrl;
		// even parity when set
		logic parity;
		// two stop bits when set
		logic stop_bits;
		// eight data bits when set, seven otherwise
		logic data_bits;
	} frame_cfg_t;

	// one received byte with its flags, read back as bits 10..0 of DATA
	typedef struct packed {
		logic       parity;
		logic       frame;
		logic       noise;
		logic [7:0] data;
	} rx_entry_t;

endpackage

/* rtl/uart_defines.svh */
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// log2 of the fifo depth, 3 gives 8 entries
`define UART_FIFO_AW 3

// host register map
`define UART_ADDR_DATA   2'd0
`define UART_ADDR_STATUS 2'd1
`define UART_ADDR_CONFIG 2'd2
`define UART_ADDR_BAUD   2'd3

// clock cycles per bit after reset
`define UART_BAUD_RESET 24'd16

`endif
